//--- rtl/ex_macros.svh
// execute stage sizing, shared by the package and the RTL
// unit numbering and slot count assume three units and two completion slots
// EX_MULT_CYCLES must be at least 2

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data and index widths
`define EX_XLEN          32
`define EX_ROB_BITS      5
`define EX_PR_BITS       6

// way and unit counts
`define EX_ISSUE_WAYS    2
`define EX_COMPLETE_WAYS 2
`define EX_N_UNITS       3

// cycles from multiplier issue to a valid product
`define EX_MULT_CYCLES   4

`endif

//--- rtl/ex_pkg.sv
// types of the execute stage
// ROB index compare is plain unsigned, no wrap-around handling

`include "ex_macros.svh"

package ex_pkg;

	//////////////////////////////////////////////////////////////////////
	// vectors
	//////////////////////////////////////////////////////////////////////

	typedef logic [`EX_XLEN-1:0]     xlen_t;
	typedef logic [`EX_ROB_BITS-1:0] rob_idx_t;
	typedef logic [`EX_PR_BITS-1:0]  pr_idx_t;

	//////////////////////////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////////////////////////

	// value doubles as position in busy vector and arbiter
	typedef enum logic [1:0] {
		UNIT_ALU0 = 2'd0,
		UNIT_ALU1 = 2'd1,
		UNIT_MULT = 2'd2
	} fu_unit_t;

	// multiplier ignores the op field
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SLTU = 3'd5
	} alu_op_t;

	typedef enum logic [1:0] {
		MULT_IDLE = 2'd0,
		MULT_RUN  = 2'd1,
		MULT_HOLD = 2'd2
	} mult_state_t;

endpackage

//--- rtl/fu_result_if.sv
// one unit's result towards arbiter and sorter, grant back to the unit
// valid holds with a stable payload until grant is seen in the same cycle

`timescale 1ns/1ps

interface fu_result_if;

	logic             valid;
	ex_pkg::rob_idx_t rob_idx;
	ex_pkg::pr_idx_t  pr_idx;
	ex_pkg::xlen_t    value;
	logic             grant;

	modport unit (
		output valid, rob_idx, pr_idx, value,
		input  grant
	);

	// grant is built from registered valid bits only
	modport arbiter (
		input  valid,
		output grant
	);

	modport sorter (
		input rob_idx, pr_idx, value
	);

endinterface

//--- rtl/exec_alu.sv
// single-cycle ALU, result registered one cycle after issue
// at most one way may address the unit per cycle, none while busy

`timescale 1ns/1ps
`include "ex_macros.svh"

module exec_alu #(
	parameter ex_pkg::fu_unit_t UNIT_ID = ex_pkg::UNIT_ALU0
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                issue_valid [`EX_ISSUE_WAYS],
	input  ex_pkg::fu_unit_t    issue_unit  [`EX_ISSUE_WAYS],
	input  ex_pkg::alu_op_t     issue_op    [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t       issue_a     [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t       issue_b     [`EX_ISSUE_WAYS],
	input  ex_pkg::rob_idx_t    issue_rob   [`EX_ISSUE_WAYS],
	input  ex_pkg::pr_idx_t     issue_pr    [`EX_ISSUE_WAYS],
	output logic                busy,
	fu_result_if.unit           result
);

	logic [`EX_ISSUE_WAYS-1:0] hit;
	logic                      sel_valid;
	ex_pkg::alu_op_t           sel_op;
	ex_pkg::xlen_t             sel_a;
	ex_pkg::xlen_t             sel_b;
	ex_pkg::rob_idx_t          sel_rob;
	ex_pkg::pr_idx_t           sel_pr;
	ex_pkg::xlen_t             alu_out;

	logic                      valid_q;
	ex_pkg::xlen_t             value_q;
	ex_pkg::rob_idx_t          rob_q;
	ex_pkg::pr_idx_t           pr_q;

	//////////////////////////////////////////////////////////////////////
	// way select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sel_valid = 1'b0;
		sel_op    = ex_pkg::ALU_ADD;
		sel_a     = '0;
		sel_b     = '0;
		sel_rob   = '0;
		sel_pr    = '0;
		for (int w = 0; w < `EX_ISSUE_WAYS; w++) begin
			hit[w] = issue_valid[w] && (issue_unit[w] == UNIT_ID);
			if (hit[w]) begin
				sel_valid = 1'b1;
				sel_op    = issue_op[w];
				sel_a     = issue_a[w];
				sel_b     = issue_b[w];
				sel_rob   = issue_rob[w];
				sel_pr    = issue_pr[w];
			end
		end
	end

	always_comb begin
		case (sel_op)
			ex_pkg::ALU_ADD:  alu_out = sel_a + sel_b;
			ex_pkg::ALU_SUB:  alu_out = sel_a - sel_b;
			ex_pkg::ALU_AND:  alu_out = sel_a & sel_b;
			ex_pkg::ALU_OR:   alu_out = sel_a | sel_b;
			ex_pkg::ALU_XOR:  alu_out = sel_a ^ sel_b;
			ex_pkg::ALU_SLTU: alu_out = ex_pkg::xlen_t'(sel_a < sel_b);
			default:          alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// result register, held until granted
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (sel_valid) begin
			valid_q <= 1'b1;
		end else if (result.grant) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (sel_valid) begin
			value_q <= alu_out;
			rob_q   <= sel_rob;
			pr_q    <= sel_pr;
		end
	end

	assign result.valid   = valid_q;
	assign result.value   = value_q;
	assign result.rob_idx = rob_q;
	assign result.pr_idx  = pr_q;

	// result waiting for a slot
	assign busy = valid_q && !result.grant;

	a_one_way: assert property (@(posedge clock) disable iff (reset)
		$countones(hit) <= 1)
		else $error("exec_alu %0d: both ways address the unit", UNIT_ID);

	a_no_issue_busy: assert property (@(posedge clock) disable iff (reset)
		!(busy && sel_valid))
		else $error("exec_alu %0d: issue while busy", UNIT_ID);

endmodule

//--- rtl/exec_mult.sv
// iterative unsigned multiplier, low XLEN bits of the product only
// product valid EX_MULT_CYCLES after issue, then held until granted
// no issue is accepted while running or while holding an ungranted result

`timescale 1ns/1ps
`include "ex_macros.svh"

module exec_mult #(
	parameter ex_pkg::fu_unit_t UNIT_ID = ex_pkg::UNIT_MULT
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                issue_valid [`EX_ISSUE_WAYS],
	input  ex_pkg::fu_unit_t    issue_unit  [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t       issue_a     [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t       issue_b     [`EX_ISSUE_WAYS],
	input  ex_pkg::rob_idx_t    issue_rob   [`EX_ISSUE_WAYS],
	input  ex_pkg::pr_idx_t     issue_pr    [`EX_ISSUE_WAYS],
	output logic                busy,
	fu_result_if.unit           result
);

	// multiplier bits consumed per RUN cycle
	localparam int STEP  = (`EX_XLEN + `EX_MULT_CYCLES - 2) / (`EX_MULT_CYCLES - 1);
	localparam int CNT_W = $clog2(`EX_MULT_CYCLES);

	logic [`EX_ISSUE_WAYS-1:0] hit;
	logic                      start;
	ex_pkg::xlen_t             sel_a;
	ex_pkg::xlen_t             sel_b;
	ex_pkg::rob_idx_t          sel_rob;
	ex_pkg::pr_idx_t           sel_pr;

	ex_pkg::mult_state_t       state;
	logic [CNT_W-1:0]          count;
	ex_pkg::xlen_t             mcand;
	ex_pkg::xlen_t             mplier;
	ex_pkg::xlen_t             acc;
	ex_pkg::xlen_t             partial;
	logic [STEP-1:0]           digit;
	ex_pkg::rob_idx_t          rob_q;
	ex_pkg::pr_idx_t           pr_q;

	always_comb begin
		start   = 1'b0;
		sel_a   = '0;
		sel_b   = '0;
		sel_rob = '0;
		sel_pr  = '0;
		for (int w = 0; w < `EX_ISSUE_WAYS; w++) begin
			hit[w] = issue_valid[w] && (issue_unit[w] == UNIT_ID);
			if (hit[w]) begin
				start   = 1'b1;
				sel_a   = issue_a[w];
				sel_b   = issue_b[w];
				sel_rob = issue_rob[w];
				sel_pr  = issue_pr[w];
			end
		end
	end

	// low digit of the multiplier times the shifted multiplicand
	assign digit   = mplier[STEP-1:0];
	assign partial = mcand * ex_pkg::xlen_t'(digit);

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ex_pkg::MULT_IDLE;
		end else begin
			case (state)
				ex_pkg::MULT_IDLE: begin
					if (start)
						state <= ex_pkg::MULT_RUN;
				end
				ex_pkg::MULT_RUN: begin
					if (count == '0)
						state <= ex_pkg::MULT_HOLD;
				end
				ex_pkg::MULT_HOLD: begin
					// back-to-back issue on the grant edge
					if (result.grant)
						state <= start ? ex_pkg::MULT_RUN : ex_pkg::MULT_IDLE;
				end
				default: state <= ex_pkg::MULT_IDLE;
			endcase
		end
	end

	// datapath, loaded on issue and stepped in RUN
	always_ff @(posedge clock) begin
		if (start) begin
			count  <= CNT_W'(`EX_MULT_CYCLES - 2);
			mcand  <= sel_a;
			mplier <= sel_b;
			acc    <= '0;
			rob_q  <= sel_rob;
			pr_q   <= sel_pr;
		end else if (state == ex_pkg::MULT_RUN) begin
			count  <= count - 1'b1;
			mcand  <= mcand << STEP;
			mplier <= mplier >> STEP;
			acc    <= acc + partial;
		end
	end

	assign result.valid   = (state == ex_pkg::MULT_HOLD);
	assign result.value   = acc;
	assign result.rob_idx = rob_q;
	assign result.pr_idx  = pr_q;

	assign busy = (state == ex_pkg::MULT_RUN)
		|| (state == ex_pkg::MULT_HOLD && !result.grant);

	a_no_issue_busy: assert property (@(posedge clock) disable iff (reset)
		!(busy && start))
		else $error("exec_mult: issue while busy");

endmodule

//--- rtl/complete_arbiter.sv
// completion arbiter, fixed priority MULT then ALU0 then ALU1
// combinational grants; slot 1 only ever used when slot 0 is

`timescale 1ns/1ps
`include "ex_macros.svh"

module complete_arbiter (
	input  logic             clock,
	input  logic             reset,
	fu_result_if.arbiter     alu0,
	fu_result_if.arbiter     alu1,
	fu_result_if.arbiter     mult,
	output logic             slot_valid [`EX_COMPLETE_WAYS],
	output ex_pkg::fu_unit_t slot_unit  [`EX_COMPLETE_WAYS]
);

	localparam ex_pkg::fu_unit_t PRIO [`EX_N_UNITS] = '{
		ex_pkg::UNIT_MULT,
		ex_pkg::UNIT_ALU0,
		ex_pkg::UNIT_ALU1
	};

	logic [`EX_N_UNITS-1:0] req;
	logic [`EX_N_UNITS-1:0] gnt;

	// request vector in unit-number order
	always_comb begin
		req                    = '0;
		req[ex_pkg::UNIT_ALU0] = alu0.valid;
		req[ex_pkg::UNIT_ALU1] = alu1.valid;
		req[ex_pkg::UNIT_MULT] = mult.valid;
	end

	//////////////////////////////////////////////////////////////////////
	// priority scan, slot 0 filled first
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int n;
		n   = 0;
		gnt = '0;
		for (int s = 0; s < `EX_COMPLETE_WAYS; s++) begin
			slot_valid[s] = 1'b0;
			slot_unit[s]  = ex_pkg::UNIT_ALU0;
		end
		for (int i = 0; i < `EX_N_UNITS; i++) begin
			if (req[PRIO[i]] && n < `EX_COMPLETE_WAYS) begin
				gnt[PRIO[i]]  = 1'b1;
				slot_valid[n] = 1'b1;
				slot_unit[n]  = PRIO[i];
				n++;
			end
		end
	end

	assign alu0.grant = gnt[ex_pkg::UNIT_ALU0];
	assign alu1.grant = gnt[ex_pkg::UNIT_ALU1];
	assign mult.grant = gnt[ex_pkg::UNIT_MULT];

	a_grant_count: assert property (@(posedge clock) disable iff (reset)
		$countones(gnt) <= `EX_COMPLETE_WAYS)
		else $error("complete_arbiter: more grants than slots");

	// a held result must get out within a bounded wait
	for (genvar u = 0; u < `EX_N_UNITS; u++) begin : g_wait
		a_no_starve: assert property (@(posedge clock) disable iff (reset)
			(req[u] && !gnt[u]) |-> ##[1:`EX_N_UNITS] gnt[u])
			else $error("complete_arbiter: unit %0d starved", u);
	end

endmodule

//--- rtl/complete_sorter.sv
// completion output stage, one cycle after grant
// two results in one cycle leave oldest first, by smaller ROB index

`timescale 1ns/1ps
`include "ex_macros.svh"

module complete_sorter (
	input  logic             clock,
	input  logic             reset,
	fu_result_if.sorter      alu0,
	fu_result_if.sorter      alu1,
	fu_result_if.sorter      mult,
	input  logic             slot_valid     [`EX_COMPLETE_WAYS],
	input  ex_pkg::fu_unit_t slot_unit      [`EX_COMPLETE_WAYS],
	output logic             complete_valid [`EX_COMPLETE_WAYS],
	output ex_pkg::rob_idx_t complete_rob   [`EX_COMPLETE_WAYS],
	output ex_pkg::pr_idx_t  complete_pr    [`EX_COMPLETE_WAYS],
	output ex_pkg::xlen_t    complete_value [`EX_COMPLETE_WAYS]
);

	ex_pkg::rob_idx_t mux_rob   [`EX_COMPLETE_WAYS];
	ex_pkg::pr_idx_t  mux_pr    [`EX_COMPLETE_WAYS];
	ex_pkg::xlen_t    mux_value [`EX_COMPLETE_WAYS];
	logic             swap;

	// payload of the unit named in each slot
	always_comb begin
		for (int s = 0; s < `EX_COMPLETE_WAYS; s++) begin
			case (slot_unit[s])
				ex_pkg::UNIT_ALU1: begin
					mux_rob[s]   = alu1.rob_idx;
					mux_pr[s]    = alu1.pr_idx;
					mux_value[s] = alu1.value;
				end
				ex_pkg::UNIT_MULT: begin
					mux_rob[s]   = mult.rob_idx;
					mux_pr[s]    = mult.pr_idx;
					mux_value[s] = mult.value;
				end
				default: begin
					mux_rob[s]   = alu0.rob_idx;
					mux_pr[s]    = alu0.pr_idx;
					mux_value[s] = alu0.value;
				end
			endcase
		end
	end

	// older means smaller index
	assign swap = slot_valid[0] && slot_valid[1] && (mux_rob[1] < mux_rob[0]);

	//////////////////////////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////////////////////////

	// valid bits unchanged by a swap, both slots are valid then
	always_ff @(posedge clock) begin
		for (int s = 0; s < `EX_COMPLETE_WAYS; s++) begin
			if (reset)
				complete_valid[s] <= 1'b0;
			else
				complete_valid[s] <= slot_valid[s];
		end
	end

	always_ff @(posedge clock) begin
		complete_rob[0]   <= swap ? mux_rob[1]   : mux_rob[0];
		complete_pr[0]    <= swap ? mux_pr[1]    : mux_pr[0];
		complete_value[0] <= swap ? mux_value[1] : mux_value[0];
		complete_rob[1]   <= swap ? mux_rob[0]   : mux_rob[1];
		complete_pr[1]    <= swap ? mux_pr[0]    : mux_pr[1];
		complete_value[1] <= swap ? mux_value[0] : mux_value[1];
	end

endmodule

//--- rtl/ex_stage.sv
// execute stage top: two ALUs, one multiplier, two completion slots
// issue to a busy unit, or both ways to one unit, is illegal

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid    [`EX_ISSUE_WAYS],
	input  ex_pkg::fu_unit_t       issue_unit     [`EX_ISSUE_WAYS],
	input  ex_pkg::alu_op_t        issue_op       [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t          issue_a        [`EX_ISSUE_WAYS],
	input  ex_pkg::xlen_t          issue_b        [`EX_ISSUE_WAYS],
	input  ex_pkg::rob_idx_t       issue_rob      [`EX_ISSUE_WAYS],
	input  ex_pkg::pr_idx_t        issue_pr       [`EX_ISSUE_WAYS],
	output logic                   complete_valid [`EX_COMPLETE_WAYS],
	output ex_pkg::rob_idx_t       complete_rob   [`EX_COMPLETE_WAYS],
	output ex_pkg::pr_idx_t        complete_pr    [`EX_COMPLETE_WAYS],
	output ex_pkg::xlen_t          complete_value [`EX_COMPLETE_WAYS],
	output logic [`EX_N_UNITS-1:0] unit_busy
);

	logic             slot_valid [`EX_COMPLETE_WAYS];
	ex_pkg::fu_unit_t slot_unit  [`EX_COMPLETE_WAYS];

	fu_result_if alu0_res ();
	fu_result_if alu1_res ();
	fu_result_if mult_res ();

	//////////////////////////////////////////////////////////////////////
	// units
	//////////////////////////////////////////////////////////////////////

	exec_alu #(.UNIT_ID(ex_pkg::UNIT_ALU0)) alu0_i (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_unit(issue_unit), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rob(issue_rob), .issue_pr(issue_pr),
		.busy(unit_busy[ex_pkg::UNIT_ALU0]), .result(alu0_res.unit)
	);

	exec_alu #(.UNIT_ID(ex_pkg::UNIT_ALU1)) alu1_i (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_unit(issue_unit), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rob(issue_rob), .issue_pr(issue_pr),
		.busy(unit_busy[ex_pkg::UNIT_ALU1]), .result(alu1_res.unit)
	);

	exec_mult #(.UNIT_ID(ex_pkg::UNIT_MULT)) mult_i (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_unit(issue_unit),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rob(issue_rob), .issue_pr(issue_pr),
		.busy(unit_busy[ex_pkg::UNIT_MULT]), .result(mult_res.unit)
	);

	//////////////////////////////////////////////////////////////////////
	// completion
	//////////////////////////////////////////////////////////////////////

	complete_arbiter arbiter_i (
		.clock(clock), .reset(reset),
		.alu0(alu0_res.arbiter), .alu1(alu1_res.arbiter), .mult(mult_res.arbiter),
		.slot_valid(slot_valid), .slot_unit(slot_unit)
	);

	complete_sorter sorter_i (
		.clock(clock), .reset(reset),
		.alu0(alu0_res.sorter), .alu1(alu1_res.sorter), .mult(mult_res.sorter),
		.slot_valid(slot_valid), .slot_unit(slot_unit),
		.complete_valid(complete_valid), .complete_rob(complete_rob),
		.complete_pr(complete_pr), .complete_value(complete_value)
	);

endmodule

//--- verif/tb_clock_gen.sv
// clock and synchronous reset for the testbench
// reset is released a small delay after a rising edge

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

//--- verif/ex_stage_tb.sv
// table-driven testbench for the execute stage
// expected results follow the op rules and the stage latencies
// scoreboard keyed by ROB index, the table never wraps the index

`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage_tb;

	localparam int MAX_ROWS    = 32;
	localparam int ROB_DEPTH   = 1 << `EX_ROB_BITS;
	localparam int N_SECT      = 4;
	localparam int DRIVE_DELAY = 1;
	localparam logic [`EX_N_UNITS-1:0] ALL_UNITS = '1;
	localparam ex_pkg::alu_op_t ALU_OPS [8] = '{
		ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_AND, ex_pkg::ALU_OR,
		ex_pkg::ALU_XOR, ex_pkg::ALU_SLTU, ex_pkg::ALU_SLTU, ex_pkg::ALU_SUB
	};

	// one issue way of a table row, lat is the expected issue to complete delay
	typedef struct packed {
		logic             valid;
		ex_pkg::fu_unit_t unit;
		ex_pkg::alu_op_t  op;
		ex_pkg::xlen_t    a;
		ex_pkg::xlen_t    b;
		ex_pkg::rob_idx_t rob;
		ex_pkg::pr_idx_t  pr;
		logic [3:0]       lat;
	} way_t;

	logic                   clock;
	logic                   reset;
	logic                   issue_valid    [`EX_ISSUE_WAYS];
	ex_pkg::fu_unit_t       issue_unit     [`EX_ISSUE_WAYS];
	ex_pkg::alu_op_t        issue_op       [`EX_ISSUE_WAYS];
	ex_pkg::xlen_t          issue_a        [`EX_ISSUE_WAYS];
	ex_pkg::xlen_t          issue_b        [`EX_ISSUE_WAYS];
	ex_pkg::rob_idx_t       issue_rob      [`EX_ISSUE_WAYS];
	ex_pkg::pr_idx_t        issue_pr       [`EX_ISSUE_WAYS];
	logic                   complete_valid [`EX_COMPLETE_WAYS];
	ex_pkg::rob_idx_t       complete_rob   [`EX_COMPLETE_WAYS];
	ex_pkg::pr_idx_t        complete_pr    [`EX_COMPLETE_WAYS];
	ex_pkg::xlen_t          complete_value [`EX_COMPLETE_WAYS];
	logic [`EX_N_UNITS-1:0] unit_busy;

	// stimulus table, busy checked at the negedge after a row is driven
	way_t                   tbl_way   [MAX_ROWS][`EX_ISSUE_WAYS];
	logic [`EX_N_UNITS-1:0] busy_mask [MAX_ROWS];
	logic [`EX_N_UNITS-1:0] busy_exp  [MAX_ROWS];
	int                     sect_end  [N_SECT];
	string                  sect_name [N_SECT];
	int                     n_rows      = 0;
	ex_pkg::rob_idx_t       next_rob    = '0;
	logic                   table_ready = 1'b0;
	logic [31:0]            lcg_state   = 32'd21448;

	// scoreboard
	logic                   pending   [ROB_DEPTH];
	ex_pkg::xlen_t          exp_value [ROB_DEPTH];
	ex_pkg::pr_idx_t        exp_pr    [ROB_DEPTH];
	int                     due       [ROB_DEPTH];
	int                     pending_count = 0;
	int                     cycle         = 0;
	int                     n_issued      = 0;
	int                     n_completed   = 0;
	int                     n_checks      = 0;
	int                     n_errors      = 0;
	int                     test_errors   = 0;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(10)) clock_gen_i (
		.clock(clock),
		.reset(reset)
	);

	ex_stage dut_i (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_unit(issue_unit), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_rob(issue_rob), .issue_pr(issue_pr),
		.complete_valid(complete_valid), .complete_rob(complete_rob),
		.complete_pr(complete_pr), .complete_value(complete_value),
		.unit_busy(unit_busy)
	);

	always @(posedge clock)
		cycle <= cycle + 1;

	//////////////////////////////////////////////////////////////////////
	// reference rules and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic ex_pkg::xlen_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic ex_pkg::xlen_t expected_result(input ex_pkg::fu_unit_t unit,
		input ex_pkg::alu_op_t op, input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
		// low half of the unsigned product
		if (unit == ex_pkg::UNIT_MULT)
			return a * b;
		case (op)
			ex_pkg::ALU_ADD:  return a + b;
			ex_pkg::ALU_SUB:  return a - b;
			ex_pkg::ALU_AND:  return a & b;
			ex_pkg::ALU_OR:   return a | b;
			ex_pkg::ALU_XOR:  return a ^ b;
			ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			default:          return '0;
		endcase
	endfunction

	function automatic logic [`EX_N_UNITS-1:0] unit_bit(input ex_pkg::fu_unit_t unit);
		logic [`EX_N_UNITS-1:0] v;
		v       = '0;
		v[unit] = 1'b1;
		return v;
	endfunction

	task automatic count_error();
		n_errors++;
		test_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("error: %s", msg);
		count_error();
	endtask

	task automatic check_value(input string name, input ex_pkg::xlen_t got,
		input ex_pkg::xlen_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_pr(input string name, input ex_pkg::pr_idx_t got,
		input ex_pkg::pr_idx_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_rob(input string name, input ex_pkg::rob_idx_t got,
		input ex_pkg::rob_idx_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%01h expected 0x%01h", name, got, exp);
			count_error();
		end
	endtask

	task automatic check_busy(input string name, input logic [`EX_N_UNITS-1:0] got,
		input logic [`EX_N_UNITS-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%01h expected 0x%01h", name, got, exp);
			count_error();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// table construction
	//////////////////////////////////////////////////////////////////////

	task automatic begin_row(input logic [`EX_N_UNITS-1:0] mask,
		input logic [`EX_N_UNITS-1:0] exp);
		for (int k = 0; k < `EX_ISSUE_WAYS; k++)
			tbl_way[n_rows][k] = '0;
		busy_mask[n_rows] = mask;
		busy_exp[n_rows]  = exp;
		n_rows++;
	endtask

	// wait_cycles is the stall the arbiter priority imposes on this result
	task automatic add_issue(input int way, input ex_pkg::fu_unit_t unit,
		input ex_pkg::alu_op_t op, input int wait_cycles);
		way_t          w;
		ex_pkg::xlen_t r;
		w.valid = 1'b1;
		w.unit  = unit;
		w.op    = op;
		w.a     = lcg_next();
		w.b     = lcg_next();
		r       = lcg_next();
		w.pr    = r[21:16];
		w.rob   = next_rob;
		if (unit == ex_pkg::UNIT_MULT)
			w.lat = 4'(`EX_MULT_CYCLES + 1 + wait_cycles);
		else
			w.lat = 4'(2 + wait_cycles);
		tbl_way[n_rows-1][way] = w;
		next_rob++;
	endtask

	task automatic build_table();
		// one ALU op per row, ways and ALUs alternate
		sect_name[0] = "alu ops";
		for (int i = 0; i < 8; i++) begin
			begin_row('0, '0);
			add_issue(i % 2, (i % 2) ? ex_pkg::UNIT_ALU1 : ex_pkg::UNIT_ALU0, ALU_OPS[i], 0);
		end
		sect_end[0] = n_rows;

		// second multiply has to wait for the first
		sect_name[1] = "multiplier";
		begin_row('0, '0);
		add_issue(0, ex_pkg::UNIT_MULT, ex_pkg::ALU_ADD, 0);
		begin_row('0, '0);
		add_issue(1, ex_pkg::UNIT_MULT, ex_pkg::ALU_ADD, 0);
		sect_end[1] = n_rows;

		// paired completions, first and third rows need the swap
		sect_name[2] = "ordered pairs";
		begin_row('0, '0);
		add_issue(0, ex_pkg::UNIT_ALU1, ex_pkg::ALU_ADD, 0);
		add_issue(1, ex_pkg::UNIT_ALU0, ex_pkg::ALU_XOR, 0);
		begin_row('0, '0);
		add_issue(0, ex_pkg::UNIT_ALU0, ex_pkg::ALU_SUB, 0);
		add_issue(1, ex_pkg::UNIT_ALU1, ex_pkg::ALU_SLTU, 0);
		begin_row('0, '0);
		add_issue(0, ex_pkg::UNIT_ALU1, ex_pkg::ALU_OR, 0);
		add_issue(1, ex_pkg::UNIT_ALU0, ex_pkg::ALU_AND, 0);
		sect_end[2] = n_rows;

		// ALUs issued so all three units finish together, ALU1 loses one cycle
		sect_name[3] = "three-way contention";
		begin_row('0, '0);
		add_issue(0, ex_pkg::UNIT_MULT, ex_pkg::ALU_ADD, 0);
		begin_row(ALL_UNITS, unit_bit(ex_pkg::UNIT_MULT));
		begin_row(ALL_UNITS, unit_bit(ex_pkg::UNIT_MULT));
		begin_row(ALL_UNITS, unit_bit(ex_pkg::UNIT_MULT));
		add_issue(0, ex_pkg::UNIT_ALU0, ex_pkg::ALU_ADD, 0);
		add_issue(1, ex_pkg::UNIT_ALU1, ex_pkg::ALU_SUB, 1);
		begin_row(ALL_UNITS, unit_bit(ex_pkg::UNIT_ALU1));
		begin_row(ALL_UNITS, '0);
		sect_end[3] = n_rows;
	endtask

	//////////////////////////////////////////////////////////////////////
	// driving and monitoring
	//////////////////////////////////////////////////////////////////////

	task automatic next_drive_point();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic drive_idle();
		for (int k = 0; k < `EX_ISSUE_WAYS; k++)
			issue_valid[k] = 1'b0;
	endtask

	function automatic logic row_blocked(input int r);
		for (int k = 0; k < `EX_ISSUE_WAYS; k++) begin
			if (tbl_way[r][k].valid && unit_busy[tbl_way[r][k].unit])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic drive_row(input int r);
		way_t w;
		int   idx;
		for (int k = 0; k < `EX_ISSUE_WAYS; k++) begin
			w              = tbl_way[r][k];
			issue_valid[k] = w.valid;
			issue_unit[k]  = w.unit;
			issue_op[k]    = w.op;
			issue_a[k]     = w.a;
			issue_b[k]     = w.b;
			issue_rob[k]   = w.rob;
			issue_pr[k]    = w.pr;
			if (w.valid) begin
				idx            = w.rob;
				pending[idx]   = 1'b1;
				exp_value[idx] = expected_result(w.unit, w.op, w.a, w.b);
				exp_pr[idx]    = w.pr;
				due[idx]       = cycle + w.lat;
				pending_count++;
				n_issued++;
			end
		end
	endtask

	// results due this cycle, lowest ROB index expected in slot 0
	task automatic check_completions();
		ex_pkg::rob_idx_t exp_rob [`EX_COMPLETE_WAYS];
		int               n_due;
		n_due = 0;
		for (int s = 0; s < `EX_COMPLETE_WAYS; s++)
			exp_rob[s] = '0;
		for (int i = 0; i < ROB_DEPTH; i++) begin
			if (pending[i] && due[i] == cycle) begin
				if (n_due < `EX_COMPLETE_WAYS)
					exp_rob[n_due] = ex_pkg::rob_idx_t'(i);
				n_due++;
			end
		end
		if (n_due > `EX_COMPLETE_WAYS)
			note_failure($sformatf("%0d results due in cycle %0d, more than the slots",
				n_due, cycle));
		for (int s = 0; s < `EX_COMPLETE_WAYS; s++) begin
			if (complete_valid[s] === 1'b1)
				n_completed++;
			check_valid($sformatf("complete_valid[%0d]", s), complete_valid[s], s < n_due);
			if (s < n_due) begin
				if (complete_valid[s] === 1'b1) begin
					check_rob($sformatf("complete_rob[%0d]", s), complete_rob[s], exp_rob[s]);
					check_value($sformatf("complete_value[%0d] rob 0x%02h", s, exp_rob[s]),
						complete_value[s], exp_value[exp_rob[s]]);
					check_pr($sformatf("complete_pr[%0d] rob 0x%02h", s, exp_rob[s]),
						complete_pr[s], exp_pr[exp_rob[s]]);
				end
				pending[exp_rob[s]] = 1'b0;
				pending_count--;
			end
		end
	endtask

	always @(negedge clock) begin
		if (table_ready && !reset)
			check_completions();
	end

	task automatic run_section(input int first, input int last);
		for (int r = first; r < last; r++) begin
			// hold the row back while an addressed unit is busy
			while (row_blocked(r)) begin
				drive_idle();
				next_drive_point();
			end
			drive_row(r);
			@(negedge clock);
			if (busy_mask[r] != '0)
				check_busy($sformatf("unit_busy row %0d", r), unit_busy & busy_mask[r],
					busy_exp[r]);
			next_drive_point();
		end
		drive_idle();
		while (pending_count > 0)
			next_drive_point();
		// idle cycles catch a late or repeated completion
		next_drive_point();
		next_drive_point();
	endtask

	task automatic report_test(input int n, input string name);
		if (test_errors == 0)
			$display("test %0d %s: pass", n, name);
		else
			$display("test %0d %s: fail, %0d errors", n, name, test_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		for (int k = 0; k < `EX_ISSUE_WAYS; k++) begin
			issue_valid[k] = 1'b0;
			issue_unit[k]  = ex_pkg::UNIT_ALU0;
			issue_op[k]    = ex_pkg::ALU_ADD;
			issue_a[k]     = '0;
			issue_b[k]     = '0;
			issue_rob[k]   = '0;
			issue_pr[k]    = '0;
		end
		for (int i = 0; i < ROB_DEPTH; i++)
			pending[i] = 1'b0;
		build_table();
		table_ready = 1'b1;

		@(negedge reset);
		test_errors = 0;
		repeat (2) begin
			@(negedge clock);
			check_busy("unit_busy", unit_busy, '0);
		end
		report_test(1, "reset state");
		next_drive_point();

		for (int t = 0; t < N_SECT; t++) begin
			test_errors = 0;
			run_section((t == 0) ? 0 : sect_end[t-1], sect_end[t]);
			report_test(t + 2, sect_name[t]);
		end

		if (n_completed != n_issued)
			note_failure($sformatf("%0d results issued but %0d completed",
				n_issued, n_completed));
		$display("tests: %0d, checks: %0d, errors: %0d, issued: %0d, completed: %0d",
			N_SECT + 1, n_checks, n_errors, n_issued, n_completed);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// each row gets a multiplier latency plus margin
	initial begin
		wait (table_ready);
		#(n_rows * (`EX_MULT_CYCLES + 4) * 100);
		$display("timeout: the stimulus table did not finish in time, %0d results pending",
			pending_count);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- ex_stage.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/fu_result_if.sv
rtl/exec_alu.sv
rtl/exec_mult.sv
rtl/complete_arbiter.sv
rtl/complete_sorter.sv
rtl/ex_stage.sv
verif/tb_clock_gen.sv
verif/ex_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the execute stage testbench with Verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module ex_stage_tb -f ex_stage.f \
	--Mdir obj_dir -o ex_stage_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/ex_stage_sim > sim.log 2>&1
cat sim.log

grep -q "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
